/* src/ifetch_config.svh */
`ifndef IFETCH_CONFIG_SVH
`define IFETCH_CONFIG_SVH

// Datapath widths
`define IF_XLEN       32        // Address and instruction word width
`define IF_REG_BITS   5         // Register number width from EX/ME

// Register number that names the PC
`define IF_PC_REG     15

// Saved branch queue
`define IF_QDEPTH     3         // Predictions that may be in flight
`define IF_PTR_BITS   2         // Wide enough for IF_QDEPTH entries

// Exception vectors, highest priority first
`define IF_VEC_DABORT 32'h0000_0010
`define IF_VEC_FIQ    32'h0000_001C
`define IF_VEC_IRQ    32'h0000_0018
`define IF_VEC_IABORT 32'h0000_000C

// First fetch after reset
`define IF_RESET_ADDR 32'h0000_0000

`endif

/* src/ifetch_pkg.sv */
`include "ifetch_config.svh"

package ifetch_pkg;

  // Address or instruction word
  typedef logic [`IF_XLEN-1:0] addr_t;

  // Exception code reported with the vector
  typedef enum logic [1:0] {
    EXC_DABORT = 2'd0,  // Data abort, highest priority
    EXC_FIQ    = 2'd1,
    EXC_IRQ    = 2'd2,
    EXC_IABORT = 2'd3   // Instruction abort, lowest
  } exc_code_t;

  // ARM condition field, bits 31:28 of an instruction
  typedef enum logic [3:0] {
    COND_EQ = 4'h0,  // Z set
    COND_NE = 4'h1,  // Z clear
    COND_CS = 4'h2,  // C set
    COND_CC = 4'h3,  // C clear
    COND_MI = 4'h4,  // N set
    COND_PL = 4'h5,  // N clear
    COND_VS = 4'h6,  // V set
    COND_VC = 4'h7,  // V clear
    COND_HI = 4'h8,  // Unsigned higher
    COND_LS = 4'h9,  // Unsigned lower or same
    COND_GE = 4'hA,  // Signed greater or equal
    COND_LT = 4'hB,  // Signed less than
    COND_GT = 4'hC,  // Signed greater than
    COND_LE = 4'hD,  // Signed less or equal
    COND_AL = 4'hE,  // Always
    COND_NV = 4'hF   // Never
  } cond_t;

  // CPSR flags, ordered N Z C V from bit 3 down
  typedef logic [3:0] flags_t;

endpackage

/* src/fetch_addr_gen.sv */
`include "ifetch_config.svh"

module fetch_addr_gen (
  input  logic                      ngclk,
  input  logic                      nreset,
  input  logic                      nwait,        // Clock enable
  input  logic                      if_enbar,     // Fetch enable, active low
  input  logic                      load_pc,      // Load to PC in ME
  input  ifetch_pkg::addr_t         me_result,
  input  ifetch_pkg::addr_t         base_me,
  input  logic [`IF_REG_BITS-1:0]   rd_me,
  input  ifetch_pkg::addr_t         ex_result,
  input  logic                      iabort,
  input  logic                      dabort,
  input  logic                      fiq_n,
  input  logic                      irq_n,
  input  logic                      mispredicted,
  input  logic                      pc_touched,
  input  logic                      pending,      // Prediction under evaluation
  input  logic                      pt,
  input  logic                      put,
  input  ifetch_pkg::addr_t         pred_target,
  input  ifetch_pkg::addr_t         saved_addr,
  output ifetch_pkg::addr_t         inst_addr,
  output logic                      exception,
  output ifetch_pkg::exc_code_t     exc_code
);

  import ifetch_pkg::*;

  addr_t exc_vector;    // Vector of highest pending exception
  addr_t pc_me;         // PC value coming back from ME
  addr_t next_addr;     // D input of the fetch address register
  logic  fetch_en;      // Stage advances this edge
  logic  async_req;     // Interrupt or instruction abort waiting

  assign fetch_en  = nwait & ~if_enbar;
  assign async_req = iabort | ~fiq_n | ~irq_n;

  // Data abort always wins; the others wait until no redirect or
  // prediction check is in progress
  assign exception = dabort |
                     (async_req & fetch_en & ~mispredicted & ~pc_touched & ~pending);

  // Vector and code by priority
  always_comb
  begin
    if (dabort)
    begin
      exc_vector = `IF_VEC_DABORT;
      exc_code   = EXC_DABORT;
    end
    else if (!fiq_n)
    begin
      exc_vector = `IF_VEC_FIQ;
      exc_code   = EXC_FIQ;
    end
    else if (!irq_n)
    begin
      exc_vector = `IF_VEC_IRQ;
      exc_code   = EXC_IRQ;
    end
    else
    begin
      exc_vector = `IF_VEC_IABORT;   // Only iabort left
      exc_code   = EXC_IABORT;
    end
  end

  // Loaded PC is the result when PC was the destination, else the
  // written-back base
  assign pc_me = (rd_me == `IF_REG_BITS'(`IF_PC_REG)) ? me_result : base_me;

  // Redirect priority
  always_comb
  begin
    if (exception)
      next_addr = exc_vector;
    else if (load_pc)
      next_addr = pc_me;           // ME stage load to PC
    else if (mispredicted)
      next_addr = saved_addr;      // Alternative path from queue
    else if (pc_touched)
      next_addr = ex_result;       // EX stage write to PC
    else if (pt | put)
      next_addr = pred_target;
    else
      next_addr = inst_addr + `IF_XLEN'd4;  // Sequential
  end

  // Fetch address register
  always_ff @(posedge ngclk or negedge nreset)
  begin
    if (!nreset)
      inst_addr <= `IF_RESET_ADDR;
    else if (fetch_en)
      inst_addr <= next_addr;
  end

endmodule

/* src/branch_predecode.sv */
`include "ifetch_config.svh"

module branch_predecode (
  input  logic [2*`IF_XLEN-1:0]  inst_bus,     // Two words from inst_addr
  input  ifetch_pkg::addr_t      inst_addr,
  input  logic                   clr_pred,     // Drop any new prediction
  output logic                   pt,           // Predict taken
  output logic                   put,          // Predict untaken
  output ifetch_pkg::addr_t      pred_target,  // Where fetch goes next
  output ifetch_pkg::addr_t      alt_addr,     // Path if prediction is wrong
  output ifetch_pkg::cond_t      save_cond,
  output ifetch_pkg::addr_t      inst_if       // Word sent to decode
);

  import ifetch_pkg::*;

  addr_t word0;          // Instruction at inst_addr
  addr_t word1;          // Instruction at inst_addr + 4
  addr_t boff;           // Offset, sign extended and word aligned
  addr_t branch_addr;    // PC + 8 + offset
  addr_t seq_addr;       // Fall-through fetch
  logic  is_uncond;      // B always
  logic  is_back;        // B with negative offset
  logic  is_fwd_cond;    // Conditional B with positive offset

  assign word0 = inst_bus[`IF_XLEN-1:0];
  assign word1 = inst_bus[2*`IF_XLEN-1:`IF_XLEN];

  // Opcode fields of B (not BL), bit 23 is the offset sign
  assign is_uncond   = (word0[31:24] == 8'hEA);
  assign is_back     = (word0[27:23] == 5'h15);
  assign is_fwd_cond = (word0[27:23] == 5'h14) & (word0[31:28] != 4'hE);

  // Backward or always branches are taken, forward conditionals are not
  // The two cases never overlap
  assign pt  = (is_uncond | is_back) & ~clr_pred;
  assign put = is_fwd_cond & ~clr_pred;

  // 24-bit offset in words
  assign boff = {{(`IF_XLEN-26){word0[23]}}, word0[23:0], 2'b00};

  // ARM PC reads as instruction address plus 8
  assign branch_addr = inst_addr + `IF_XLEN'd8 + boff;
  assign seq_addr    = inst_addr + `IF_XLEN'd4;

  // Taken goes to the target and saves fall-through,
  // untaken the other way round
  always_comb
  begin
    if (pt)
    begin
      pred_target = branch_addr;
      alt_addr    = seq_addr;
    end
    else
    begin
      pred_target = seq_addr;
      alt_addr    = branch_addr;     // Only stored when put
    end
  end

  assign save_cond = cond_t'(word0[31:28]);

  // Untaken branch itself is swallowed, decode gets the next word
  assign inst_if = put ? word1 : word0;

endmodule

/* src/branch_queue.sv */
`include "ifetch_config.svh"

module branch_queue (
  input  logic               ngclk,
  input  logic               nreset,
  input  logic               nwait,
  input  logic               if_enbar,
  input  logic               pt,
  input  logic               put,
  input  ifetch_pkg::addr_t  alt_addr,
  input  ifetch_pkg::cond_t  save_cond,
  input  logic               eval,        // Oldest record checked this cycle
  input  logic               clr_pred,
  output ifetch_pkg::addr_t  saved_addr,
  output ifetch_pkg::cond_t  saved_cond,
  output logic               saved_taken
);

  import ifetch_pkg::*;

  addr_t                   q_addr  [`IF_QDEPTH];   // Alternative path
  cond_t                   q_cond  [`IF_QDEPTH];   // Branch condition
  logic                    q_taken [`IF_QDEPTH];   // Predicted direction
  logic [`IF_PTR_BITS-1:0] open_ptr;               // Next free record
  logic [`IF_PTR_BITS-1:0] eval_ptr;               // Record under test
  logic                    wr_en;

  // Rotate modulo depth, stray codes go back to 0
  function automatic logic [`IF_PTR_BITS-1:0] bump(input logic [`IF_PTR_BITS-1:0] p);
    if (p >= `IF_PTR_BITS'(`IF_QDEPTH - 1))
      return '0;
    else
      return p + `IF_PTR_BITS'(1);
  endfunction

  assign wr_en = nwait & ~if_enbar & (pt | put);

  // Pointers
  always_ff @(posedge ngclk or negedge nreset)
  begin
    if (!nreset)
    begin
      open_ptr <= '0;
      eval_ptr <= '0;
    end
    else if (nwait)
    begin
      if (clr_pred)
      begin
        open_ptr <= '0;          // Every prediction in flight dropped
        eval_ptr <= '0;
      end
      else
      begin
        if (wr_en)
          open_ptr <= bump(open_ptr);
        if (eval)
          eval_ptr <= bump(eval_ptr);
      end
    end
  end

  // Records
  always_ff @(posedge ngclk)
  begin
    if (wr_en && open_ptr < `IF_PTR_BITS'(`IF_QDEPTH))
    begin
      q_taken[open_ptr] <= pt;
      q_cond[open_ptr]  <= save_cond;
      q_addr[open_ptr]  <= alt_addr;
    end
  end

  // Read port at the evaluate pointer
  always_comb
  begin
    if (eval_ptr < `IF_PTR_BITS'(`IF_QDEPTH))
    begin
      saved_addr  = q_addr[eval_ptr];
      saved_cond  = q_cond[eval_ptr];
      saved_taken = q_taken[eval_ptr];
    end
    else
    begin
      saved_addr  = q_addr[0];
      saved_cond  = q_cond[0];
      saved_taken = q_taken[0];
    end
  end

endmodule

/* src/branch_resolve.sv */
`include "ifetch_config.svh"

module branch_resolve (
  input  logic                     ngclk,
  input  logic                     nreset,
  input  logic                     nwait,
  input  logic                     if_enbar,
  input  logic                     pt,
  input  logic                     put,
  input  logic                     hold_next_ex,   // EX stalled
  input  ifetch_pkg::flags_t       flags,
  input  ifetch_pkg::cond_t        saved_cond,
  input  logic                     saved_taken,
  input  logic [`IF_REG_BITS-1:0]  rd_ex,
  input  logic                     write_rd_ex,
  input  logic                     load_pc_ex,     // Load to PC coming from ME
  input  logic                     load_pc,
  input  logic                     dabort,
  output logic                     eval,           // Predicted branch in EX
  output logic                     pending,
  output logic                     mispredicted,
  output logic                     pc_touched,
  output logic                     clr_pred
);

  import ifetch_pkg::*;

  logic wait_id;     // Predicted branch now in ID
  logic cond_true;   // Saved condition passes on flags
  logic n_f;
  logic z_f;
  logic c_f;
  logic v_f;

  assign n_f = flags[3];
  assign z_f = flags[2];
  assign c_f = flags[1];
  assign v_f = flags[0];

  // Timer, two enabled edges from prediction to eval
  always_ff @(posedge ngclk or negedge nreset)
  begin
    if (!nreset)
    begin
      wait_id <= 1'b0;
      eval    <= 1'b0;
    end
    else if (nwait)
    begin
      if (!if_enbar)
        wait_id <= (pt | put | (wait_id & hold_next_ex)) & ~clr_pred;
      else if (!hold_next_ex)
        wait_id <= 1'b0;         // Pipe moved on without fetch
      eval <= wait_id & ~(clr_pred | hold_next_ex);
    end
  end

  assign pending = wait_id | eval;

  // Condition check
  always_comb
  begin
    case (saved_cond)
      COND_EQ: cond_true = z_f;
      COND_NE: cond_true = ~z_f;
      COND_CS: cond_true = c_f;
      COND_CC: cond_true = ~c_f;
      COND_MI: cond_true = n_f;
      COND_PL: cond_true = ~n_f;
      COND_VS: cond_true = v_f;
      COND_VC: cond_true = ~v_f;
      COND_HI: cond_true = c_f & ~z_f;
      COND_LS: cond_true = ~c_f | z_f;
      COND_GE: cond_true = (n_f == v_f);
      COND_LT: cond_true = (n_f != v_f);
      COND_GT: cond_true = ~z_f & (n_f == v_f);
      COND_LE: cond_true = z_f | (n_f != v_f);
      COND_AL: cond_true = 1'b1;
      default: cond_true = 1'b0;   // NV
    endcase
  end

  // Wrong guess when direction and outcome disagree
  assign mispredicted = eval & (saved_taken != cond_true);

  // Data processing write to PC in EX, loads are caught in ME
  assign pc_touched = (rd_ex == `IF_REG_BITS'(`IF_PC_REG)) & write_rd_ex & ~load_pc_ex;

  assign clr_pred = pc_touched | mispredicted | dabort | load_pc_ex | load_pc;

endmodule

/* src/ifetch_top.sv */
`include "ifetch_config.svh"

module ifetch_top (
  input  logic                     ngclk,
  input  logic                     nreset,
  input  logic                     nwait,
  input  logic                     if_enbar,
  input  logic [2*`IF_XLEN-1:0]    inst_bus,
  input  ifetch_pkg::flags_t       flags,
  input  logic                     load_pc,
  input  logic                     load_pc_ex,
  input  ifetch_pkg::addr_t        me_result,
  input  ifetch_pkg::addr_t        base_me,
  input  ifetch_pkg::addr_t        ex_result,
  input  logic [`IF_REG_BITS-1:0]  rd_me,
  input  logic [`IF_REG_BITS-1:0]  rd_ex,
  input  logic                     write_rd_ex,
  input  logic                     hold_next_ex,
  input  logic                     iabort,
  input  logic                     dabort,
  input  logic                     fiq_n,
  input  logic                     irq_n,
  output ifetch_pkg::addr_t        inst_addr,
  output ifetch_pkg::addr_t        inst_if,
  output ifetch_pkg::exc_code_t    exc_code,
  output logic                     exception,
  output logic                     mispredicted,
  output logic                     pc_touched,
  output logic                     eval,
  output logic                     pt,
  output logic                     put
);

  import ifetch_pkg::*;

  addr_t pred_target;
  addr_t alt_addr;
  addr_t saved_addr;
  cond_t save_cond;
  cond_t saved_cond;
  logic  saved_taken;
  logic  clr_pred;
  logic  pending;

  fetch_addr_gen u_fetch_addr_gen (
    .ngclk        (ngclk),
    .nreset       (nreset),
    .nwait        (nwait),
    .if_enbar     (if_enbar),
    .load_pc      (load_pc),
    .me_result    (me_result),
    .base_me      (base_me),
    .rd_me        (rd_me),
    .ex_result    (ex_result),
    .iabort       (iabort),
    .dabort       (dabort),
    .fiq_n        (fiq_n),
    .irq_n        (irq_n),
    .mispredicted (mispredicted),
    .pc_touched   (pc_touched),
    .pending      (pending),
    .pt           (pt),
    .put          (put),
    .pred_target  (pred_target),
    .saved_addr   (saved_addr),
    .inst_addr    (inst_addr),
    .exception    (exception),
    .exc_code     (exc_code)
  );

  branch_predecode u_branch_predecode (
    .inst_bus    (inst_bus),
    .inst_addr   (inst_addr),
    .clr_pred    (clr_pred),
    .pt          (pt),
    .put         (put),
    .pred_target (pred_target),
    .alt_addr    (alt_addr),
    .save_cond   (save_cond),
    .inst_if     (inst_if)
  );

  branch_queue u_branch_queue (
    .ngclk       (ngclk),
    .nreset      (nreset),
    .nwait       (nwait),
    .if_enbar    (if_enbar),
    .pt          (pt),
    .put         (put),
    .alt_addr    (alt_addr),
    .save_cond   (save_cond),
    .eval        (eval),
    .clr_pred    (clr_pred),
    .saved_addr  (saved_addr),
    .saved_cond  (saved_cond),
    .saved_taken (saved_taken)
  );

  branch_resolve u_branch_resolve (
    .ngclk        (ngclk),
    .nreset       (nreset),
    .nwait        (nwait),
    .if_enbar     (if_enbar),
    .pt           (pt),
    .put          (put),
    .hold_next_ex (hold_next_ex),
    .flags        (flags),
    .saved_cond   (saved_cond),
    .saved_taken  (saved_taken),
    .rd_ex        (rd_ex),
    .write_rd_ex  (write_rd_ex),
    .load_pc_ex   (load_pc_ex),
    .load_pc      (load_pc),
    .dabort       (dabort),
    .eval         (eval),
    .pending      (pending),
    .mispredicted (mispredicted),
    .pc_touched   (pc_touched),
    .clr_pred     (clr_pred)
  );

endmodule

/* testbench/tb_ifetch.sv */
`include "ifetch_config.svh"

module tb_ifetch;
  timeunit 1ns;
  timeprecision 10ps;

  import ifetch_pkg::*;

  localparam int CLK_PERIOD = 40;

  // Cycle budget per test for the watchdog
  localparam int T_RESET       = 4;
  localparam int T_SEQ         = 16;
  localparam int T_EXC         = 10;
  localparam int T_REDIR       = 8;
  localparam int T_TAKEN       = 8;
  localparam int T_UNTAKEN     = 9;
  localparam int TEST_CYCLES   = T_RESET + T_SEQ + T_EXC + T_REDIR + T_TAKEN + T_UNTAKEN;
  localparam int MARGIN_CYCLES = 20;

  localparam addr_t TAKEN_AT    = 32'h0000_0080;  // BEQ backward lives here
  localparam int    TAKEN_OFF   = -6;             // In words
  localparam addr_t UNTAKEN_AT  = 32'h0000_00C0;  // BNE forward lives here
  localparam int    UNTAKEN_OFF = 16;

  logic                    ngclk;
  logic                    nreset;
  logic                    nwait;
  logic                    if_enbar;
  logic [2*`IF_XLEN-1:0]   inst_bus;
  flags_t                  flags;
  logic                    load_pc;
  logic                    load_pc_ex;
  addr_t                   me_result;
  addr_t                   base_me;
  addr_t                   ex_result;
  logic [`IF_REG_BITS-1:0] rd_me;
  logic [`IF_REG_BITS-1:0] rd_ex;
  logic                    write_rd_ex;
  logic                    hold_next_ex;
  logic                    iabort;
  logic                    dabort;
  logic                    fiq_n;
  logic                    irq_n;
  addr_t                   inst_addr;
  addr_t                   inst_if;
  exc_code_t               exc_code;
  logic                    exception;
  logic                    mispredicted;
  logic                    pc_touched;
  logic                    eval;
  logic                    pt;
  logic                    put;

  addr_t       imem [128];   // 512 bytes that wrap around
  logic [6:0]  widx;
  logic [6:0]  widx_next;
  int          checks;
  int          errors;

  // Combinational read of two words from the fetch address
  assign widx      = inst_addr[8:2];
  assign widx_next = widx + 7'd1;
  assign inst_bus  = {imem[widx_next], imem[widx]};

  ifetch_top UUT (.*);

  initial
  begin
    ngclk = 1'b0;
    forever #(CLK_PERIOD/2) ngclk = ~ngclk;
  end

  initial
  begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, run stopped", TEST_CYCLES + MARGIN_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  // Bits 27:25 cleared so never a branch
  function automatic addr_t filler_word();
    return $urandom() & 32'hF1FF_FFFF;
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks = checks + 1;
    if (actual !== expected)
    begin
      errors = errors + 1;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic test_sequential();
    addr_t expected;
    expected = `IF_RESET_ADDR;
    @(negedge ngclk);
    compare("seq_reset", expected, inst_addr);
    repeat (6)
    begin
      @(posedge ngclk);
      @(negedge ngclk);
      expected = expected + 32'd4;
      compare("seq_step", expected, inst_addr);
    end
    @(posedge ngclk);
    if_enbar <= 1'b1;                  // This edge still advances
    @(negedge ngclk);
    expected = expected + 32'd4;
    compare("seq_last", expected, inst_addr);
    repeat (2)
    begin
      @(posedge ngclk);
      @(negedge ngclk);
      compare("seq_hold_enbar", expected, inst_addr);
    end
    @(posedge ngclk);
    if_enbar <= 1'b0;
    nwait    <= 1'b0;
    @(negedge ngclk);
    compare("seq_hold_enbar_end", expected, inst_addr);
    repeat (2)
    begin
      @(posedge ngclk);
      @(negedge ngclk);
      compare("seq_hold_nwait", expected, inst_addr);
    end
    @(posedge ngclk);
    nwait <= 1'b1;
    @(negedge ngclk);
    compare("seq_hold_nwait_end", expected, inst_addr);
    @(posedge ngclk);
    @(negedge ngclk);
    compare("seq_resume", expected + 32'd4, inst_addr);
  endtask

  task automatic exc_case(input string name, input logic dab, input logic fiq,
                          input logic irq, input logic iab, input addr_t vec,
                          input exc_code_t code);
    @(posedge ngclk);
    dabort <= dab;
    fiq_n  <= ~fiq;
    irq_n  <= ~irq;
    iabort <= iab;
    @(negedge ngclk);
    compare({name, "_exception"}, 32'd1, 32'(exception));
    compare({name, "_code"}, 32'(code), 32'(exc_code));
    @(posedge ngclk);
    dabort <= 1'b0;                    // Vector taken on this edge
    fiq_n  <= 1'b1;
    irq_n  <= 1'b1;
    iabort <= 1'b0;
    @(negedge ngclk);
    compare({name, "_vector"}, vec, inst_addr);
  endtask

  task automatic test_exceptions();
    exc_case("exc_all", 1'b1, 1'b1, 1'b1, 1'b1, `IF_VEC_DABORT, EXC_DABORT);
    exc_case("exc_fiq", 1'b0, 1'b1, 1'b1, 1'b1, `IF_VEC_FIQ, EXC_FIQ);
    exc_case("exc_irq", 1'b0, 1'b0, 1'b1, 1'b1, `IF_VEC_IRQ, EXC_IRQ);
    exc_case("exc_iabort", 1'b0, 1'b0, 1'b0, 1'b1, `IF_VEC_IABORT, EXC_IABORT);
  endtask

  task automatic redirect_me(input string name, input logic [`IF_REG_BITS-1:0] rd,
                             input addr_t result, input addr_t base, input addr_t expected);
    @(posedge ngclk);
    load_pc   <= 1'b1;
    rd_me     <= rd;
    me_result <= result;
    base_me   <= base;
    @(posedge ngclk);
    load_pc <= 1'b0;
    @(negedge ngclk);
    compare(name, expected, inst_addr);
  endtask

  // PC write from EX that also lands on a test branch
  task automatic jump_ex(input string name, input addr_t target);
    @(posedge ngclk);
    rd_ex       <= `IF_PC_REG;
    write_rd_ex <= 1'b1;
    ex_result   <= target;
    @(negedge ngclk);
    compare({name, "_pc_touched"}, 32'd1, 32'(pc_touched));
    @(posedge ngclk);
    write_rd_ex <= 1'b0;
    @(negedge ngclk);
    compare(name, target, inst_addr);
  endtask

  task automatic test_redirects();
    redirect_me("me_result", `IF_PC_REG, 32'h0000_0140, 32'h0000_0100, 32'h0000_0140);
    redirect_me("me_base", 5'd3, 32'h0000_01A0, 32'h0000_00F0, 32'h0000_00F0);
    jump_ex("ex_write", 32'h0000_0060);
  endtask

  task automatic test_taken();
    addr_t target;
    target = TAKEN_AT + 32'd8 + 32'(TAKEN_OFF * 4);
    imem[TAKEN_AT[8:2]] = {4'h0, 4'hA, 24'(TAKEN_OFF)};
    @(posedge ngclk);
    flags <= 4'b0100;                  // Z set so EQ holds
    jump_ex("taken_jump", TAKEN_AT);
    compare("taken_pt", 32'd1, 32'(pt));
    compare("taken_put", 32'd0, 32'(put));
    @(posedge ngclk);
    @(negedge ngclk);
    compare("taken_target", target, inst_addr);
    compare("taken_eval_early", 32'd0, 32'(eval));
    imem[TAKEN_AT[8:2]] = filler_word();   // No second pass through the loop
    @(posedge ngclk);
    @(negedge ngclk);
    compare("taken_eval", 32'd1, 32'(eval));
    compare("taken_mispredicted", 32'd0, 32'(mispredicted));
  endtask

  task automatic test_untaken();
    addr_t target;
    addr_t word1;
    target = UNTAKEN_AT + 32'd8 + 32'(UNTAKEN_OFF * 4);
    imem[UNTAKEN_AT[8:2]] = {4'h1, 4'hA, 24'(UNTAKEN_OFF)};
    word1 = imem[UNTAKEN_AT[8:2] + 7'd1];
    @(posedge ngclk);
    flags <= 4'b0000;                  // Z clear so NE holds
    jump_ex("untaken_jump", UNTAKEN_AT);
    compare("untaken_put", 32'd1, 32'(put));
    compare("untaken_pt", 32'd0, 32'(pt));
    compare("untaken_inst_if", word1, inst_if);
    @(posedge ngclk);
    @(negedge ngclk);
    compare("untaken_fallthrough", UNTAKEN_AT + 32'd4, inst_addr);
    compare("untaken_eval_early", 32'd0, 32'(eval));
    imem[UNTAKEN_AT[8:2]] = filler_word();
    @(posedge ngclk);
    @(negedge ngclk);
    compare("untaken_eval", 32'd1, 32'(eval));
    compare("untaken_mispredicted", 32'd1, 32'(mispredicted));
    @(posedge ngclk);
    @(negedge ngclk);
    compare("untaken_recover", target, inst_addr);
    compare("untaken_eval_done", 32'd0, 32'(eval));
  endtask

  initial
  begin
    void'($urandom(32'hf67d_d99d));    // Seed the generator
    checks = 0;
    errors = 0;
    for (int i = 0; i < 128; i++)
      imem[i] = filler_word();
    nreset       = 1'b0;
    nwait        = 1'b1;
    if_enbar     = 1'b0;
    flags        = '0;
    load_pc      = 1'b0;
    load_pc_ex   = 1'b0;
    me_result    = '0;
    base_me      = '0;
    ex_result    = '0;
    rd_me        = '0;
    rd_ex        = '0;
    write_rd_ex  = 1'b0;
    hold_next_ex = 1'b0;
    iabort       = 1'b0;
    dabort       = 1'b0;
    fiq_n        = 1'b1;
    irq_n        = 1'b1;
    repeat (2) @(posedge ngclk);
    nreset <= 1'b1;
    test_sequential();
    test_exceptions();
    test_redirects();
    test_taken();
    test_untaken();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* all.f */
+incdir+src
src/ifetch_pkg.sv
src/fetch_addr_gen.sv
src/branch_predecode.sv
src/branch_queue.sv
src/branch_resolve.sv
src/ifetch_top.sv
testbench/tb_ifetch.sv

/* Bender.yml */
package:
  name: ifetch

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/ifetch_pkg.sv
      - src/fetch_addr_gen.sv
      - src/branch_predecode.sv
      - src/branch_queue.sv
      - src/branch_resolve.sv
      - src/ifetch_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_ifetch.sv
